//--- hw/mips16_macros.svh
`ifndef MIPS16_MACROS_SVH
`define MIPS16_MACROS_SVH

// Datapath width
`define WORD_W 16

// R0 to R7, SP, IH and T
`define REG_COUNT 11

// SLL, SRA and SRL shift by this when the count field is zero
`define SHIFT_DEFAULT 8

`endif

//--- hw/mips16_pkg.sv
`include "mips16_macros.svh"

package mips16_pkg;

	typedef logic [3:0] reg_idx_t; // 0-7 R0..R7, then SP, IH, T

	localparam reg_idx_t REG_SP = 4'd8;
	localparam reg_idx_t REG_IH = 4'd9;
	localparam reg_idx_t REG_T  = 4'd10;

	typedef enum logic [1:0] {
		SRC_REG  = 2'd0,
		SRC_IMM  = 2'd1, // Extension already applied
		SRC_PC   = 2'd2,
		SRC_ZERO = 2'd3
	} operand_src_t;

	// Major opcode, instr[15:11]
	typedef enum logic [4:0] {
		OP_NOP    = 5'b00001,
		OP_B      = 5'b00010,
		OP_BEQZ   = 5'b00100,
		OP_BNEZ   = 5'b00101,
		OP_SHIFT  = 5'b00110, // SLL, SRL, SRA
		OP_ADDIU3 = 5'b01000,
		OP_ADDIU  = 5'b01001,
		OP_SP_GRP = 5'b01100, // ADDSP, BTEQZ, MTSP
		OP_LI     = 5'b01101,
		OP_MOVE   = 5'b01111,
		OP_LW_SP  = 5'b10010,
		OP_LW     = 5'b10011,
		OP_SW_SP  = 5'b11010,
		OP_SW     = 5'b11011,
		OP_ADDSUB = 5'b11100,
		OP_RR_GRP = 5'b11101, // Register-register ops and jumps
		OP_IH_GRP = 5'b11110  // MFIH, MTIH
	} major_op_t;

	typedef struct packed {
		operand_src_t       src_a;
		operand_src_t       src_b;
		reg_idx_t           idx_a;
		reg_idx_t           idx_b;
		logic [`WORD_W-1:0] imm;
		logic               wb_en;
		reg_idx_t           wb_idx;
		logic               wb_flag; // CMP writes the flag into T
	} decode_t;

	typedef enum logic [1:0] {IDLE, EXEC, ACK, RELEASE} exec_state_t;

endpackage

//--- hw/alu_if.sv
`timescale 1ns/1ps
`include "mips16_macros.svh"

// Decoder feeds the ALU, controller samples its outputs
interface alu_if;

	logic [`WORD_W-1:0] opn; // Instruction word used as opcode
	logic [`WORD_W-1:0] op1;
	logic [`WORD_W-1:0] op2;
	logic [`WORD_W-1:0] res;
	logic               flag; // Carry, compare or branch-taken

	modport decode (output opn, op1, op2);

	modport alu (
		input  opn, op1, op2,
		output res, flag
	);

	modport ctrl (input res, flag);

endinterface

//--- hw/operand_decode.sv
`timescale 1ns/1ps
`include "mips16_macros.svh"

module operand_decode import mips16_pkg::*; (
	input  logic [`WORD_W-1:0] instr,
	input  logic [`WORD_W-1:0] pc,
	output reg_idx_t           rd_idx_a,
	output reg_idx_t           rd_idx_b,
	input  logic [`WORD_W-1:0] rd_data_a,
	input  logic [`WORD_W-1:0] rd_data_b,
	output decode_t            dec,
	alu_if.decode              bus
);

	localparam logic [`WORD_W-1:0] SHIFT_DFLT = `SHIFT_DEFAULT;

	reg_idx_t           rx;
	reg_idx_t           ry;
	reg_idx_t           rz;
	logic [`WORD_W-1:0] se4;
	logic [`WORD_W-1:0] se5;
	logic [`WORD_W-1:0] se8;
	logic [`WORD_W-1:0] se11;
	logic [`WORD_W-1:0] ze8;
	logic [`WORD_W-1:0] shamt;

	assign rx = {1'b0, instr[10:8]};
	assign ry = {1'b0, instr[7:5]};
	assign rz = {1'b0, instr[4:2]};

	assign se4   = {{(`WORD_W-4){instr[3]}}, instr[3:0]};   // ADDIU3
	assign se5   = {{(`WORD_W-5){instr[4]}}, instr[4:0]};   // LW, SW offset
	assign se8   = {{(`WORD_W-8){instr[7]}}, instr[7:0]};
	assign se11  = {{(`WORD_W-11){instr[10]}}, instr[10:0]}; // B offset
	assign ze8   = {{(`WORD_W-8){1'b0}}, instr[7:0]};         // LI only
	assign shamt = (instr[4:2] == 3'd0) ? SHIFT_DFLT : {{(`WORD_W-3){1'b0}}, instr[4:2]};

	////////////////////////////////////////////////////////////////////////////
	// Field decode

	always_comb begin
		dec        = '0;
		dec.src_a  = SRC_ZERO;
		dec.src_b  = SRC_ZERO;
		dec.idx_a  = rx;
		dec.idx_b  = ry;
		dec.imm    = se8;
		dec.wb_idx = rx;
		case (instr[15:11])
			OP_ADDIU: begin
				dec.src_a = SRC_REG;
				dec.src_b = SRC_IMM;
				dec.wb_en = 1'b1;
			end
			OP_ADDIU3: begin
				dec.src_a  = SRC_REG;
				dec.src_b  = SRC_IMM;
				dec.imm    = se4;
				dec.wb_en  = 1'b1;
				dec.wb_idx = ry;
			end
			OP_SP_GRP: begin
				dec.src_a = SRC_REG;
				dec.src_b = SRC_IMM;
				case (instr[10:8])
					3'b011: begin // ADDSP
						dec.idx_a  = REG_SP;
						dec.wb_en  = 1'b1;
						dec.wb_idx = REG_SP;
					end
					3'b000: dec.idx_a = REG_T; // BTEQZ tests T
					3'b100: begin // MTSP
						dec.idx_a  = ry;
						dec.wb_en  = 1'b1;
						dec.wb_idx = REG_SP;
					end
					default: ;
				endcase
			end
			OP_ADDSUB: begin
				dec.src_a  = SRC_REG;
				dec.src_b  = SRC_REG;
				dec.wb_en  = 1'b1;
				dec.wb_idx = rz;
			end
			OP_RR_GRP: begin
				dec.src_a = SRC_REG;
				dec.src_b = SRC_REG;
				case (instr[4:0])
					5'b01100, 5'b01101: dec.wb_en = 1'b1; // AND, OR
					5'b01010: begin // CMP
						dec.wb_en   = 1'b1;
						dec.wb_flag = 1'b1;
						dec.wb_idx  = REG_T;
					end
					5'b00111: begin // SRAV, ry shifted by rx
						dec.idx_a  = ry;
						dec.idx_b  = rx;
						dec.wb_en  = 1'b1;
						dec.wb_idx = ry;
					end
					5'b00000: begin
						if (instr[7:0] == 8'h40) begin // MFPC
							dec.src_a = SRC_PC;
							dec.wb_en = 1'b1;
						end else if (instr[10:0] == 11'h020) begin
							dec.src_a = SRC_ZERO; // JRRA, RA is not held here
						end
					end
					default: ;
				endcase
			end
			OP_B: begin
				dec.src_a = SRC_PC;
				dec.src_b = SRC_IMM;
				dec.imm   = se11;
			end
			OP_BEQZ, OP_BNEZ: begin
				dec.src_a = SRC_REG;
				dec.src_b = SRC_IMM;
			end
			OP_LI: begin
				dec.src_a = SRC_IMM;
				dec.imm   = ze8;
				dec.wb_en = 1'b1;
			end
			OP_LW, OP_SW: begin // Address only, no memory
				dec.src_a = SRC_REG;
				dec.src_b = SRC_IMM;
				dec.imm   = se5;
			end
			OP_LW_SP: begin
				dec.src_a = SRC_REG;
				dec.src_b = SRC_IMM;
				dec.idx_a = REG_SP;
			end
			OP_SW_SP: dec.src_a = SRC_REG; // Store data reported
			OP_IH_GRP: begin
				dec.src_a = SRC_REG;
				if (instr[7:0] == 8'h00) begin // MFIH
					dec.idx_a = REG_IH;
					dec.wb_en = 1'b1;
				end else if (instr[7:0] == 8'h01) begin // MTIH
					dec.wb_en  = 1'b1;
					dec.wb_idx = REG_IH;
				end
			end
			OP_SHIFT: begin
				dec.idx_a = ry;
				dec.src_a = SRC_REG;
				dec.src_b = SRC_IMM;
				dec.imm   = shamt;
				dec.wb_en = (instr[1:0] != 2'b01);
			end
			OP_MOVE: begin
				dec.idx_a = ry;
				dec.src_a = SRC_REG;
				dec.wb_en = (instr[4:0] == 5'b00000);
			end
			default: ; // NOP and unknown words do nothing
		endcase
	end

	function automatic logic [`WORD_W-1:0] pick_operand(
		input operand_src_t       src,
		input logic [`WORD_W-1:0] rd_data,
		input logic [`WORD_W-1:0] imm,
		input logic [`WORD_W-1:0] pc_val
	);
		case (src)
			SRC_REG: return rd_data;
			SRC_IMM: return imm;
			SRC_PC:  return pc_val;
			default: return '0;
		endcase
	endfunction

	assign rd_idx_a = dec.idx_a;
	assign rd_idx_b = dec.idx_b;

	assign bus.opn = instr;
	assign bus.op1 = pick_operand(dec.src_a, rd_data_a, dec.imm, pc);
	assign bus.op2 = pick_operand(dec.src_b, rd_data_b, dec.imm, pc);

endmodule

//--- hw/reg_file.sv
`timescale 1ns/1ps
`include "mips16_macros.svh"

module reg_file import mips16_pkg::*; (
	input  logic               clk,
	input  logic               arst_n,
	input  reg_idx_t           rd_idx_a,
	input  reg_idx_t           rd_idx_b,
	output logic [`WORD_W-1:0] rd_data_a,
	output logic [`WORD_W-1:0] rd_data_b,
	input  logic               wr_en,
	input  reg_idx_t           wr_idx,
	input  logic [`WORD_W-1:0] wr_data
);

	logic [`WORD_W-1:0] regs [`REG_COUNT]; // R0-R7, SP, IH, T

	////////////////////////////////////////////////////////////////////////////
	// Write port

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0; // Program starts from all-zero state
			end
		end else if (wr_en && (wr_idx < `REG_COUNT)) begin
			regs[wr_idx] <= wr_data;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read ports, combinational

	assign rd_data_a = (rd_idx_a < `REG_COUNT) ? regs[rd_idx_a] : '0; // Index 11-15 reads 0
	assign rd_data_b = (rd_idx_b < `REG_COUNT) ? regs[rd_idx_b] : '0;

	// Writeback target comes from the decoder through the controller,
	// an out-of-range index there would be dropped without notice
	a_wr_idx_range: assert property (
		@(posedge clk) disable iff (!arst_n)
		wr_en |-> (wr_idx < `REG_COUNT)
	) else $error("reg_file: write to index %0d", wr_idx);

endmodule

//--- hw/alu.sv
`timescale 1ns/1ps
`include "mips16_macros.svh"

module alu import mips16_pkg::*; (
	alu_if.alu bus
);

	logic [`WORD_W:0]   sum;  // Bit 16 is the carry
	logic [`WORD_W:0]   diff; // Bit 16 is the borrow
	logic [`WORD_W:0]   shl;  // Bit 16 catches the last bit shifted out
	logic [`WORD_W-1:0] sra;
	logic [`WORD_W-1:0] srl;

	assign sum  = {1'b0, bus.op1} + {1'b0, bus.op2};
	assign diff = {1'b0, bus.op1} - {1'b0, bus.op2};
	assign shl  = {1'b0, bus.op1} << bus.op2;
	assign sra  = $signed(bus.op1) >>> bus.op2;
	assign srl  = bus.op1 >> bus.op2;

	////////////////////////////////////////////////////////////////////////////
	// Opcode table

	always_comb begin
		bus.res  = '0;
		bus.flag = 1'b0;
		case (bus.opn[15:11])
			OP_ADDIU, OP_ADDIU3, OP_B, OP_LW, OP_SW: begin
				{bus.flag, bus.res} = sum; // B target, LW/SW address
			end
			OP_SP_GRP: begin
				if (bus.opn[10:8] == 3'b011) begin // ADDSP
					{bus.flag, bus.res} = sum;
				end else if (bus.opn[10:8] == 3'b000) begin // BTEQZ
					bus.flag = (bus.op1 == '0);
				end else if (bus.opn[10:8] == 3'b100 && bus.opn[4:0] == 5'b00000) begin
					bus.res = bus.op1; // MTSP
				end
			end
			OP_ADDSUB: begin
				if (bus.opn[1:0] == 2'b01) begin // ADDU
					{bus.flag, bus.res} = sum;
				end else if (bus.opn[1:0] == 2'b11) begin // SUBU
					{bus.flag, bus.res} = diff;
				end
			end
			OP_RR_GRP: begin
				if (bus.opn[4:0] == 5'b01100) begin // AND
					bus.res = bus.op1 & bus.op2;
				end else if (bus.opn[7:0] == 8'h00) begin // JR
					bus.res = bus.op1;
				end else if (bus.opn[4:0] == 5'b01010) begin // CMP, set when different
					bus.flag = (bus.op1 != bus.op2);
				end else if (bus.opn[7:0] == 8'h40) begin // MFPC
					bus.res = bus.op1;
				end else if (bus.opn[4:0] == 5'b01101) begin // OR
					bus.res = bus.op1 | bus.op2;
				end else if (bus.opn[7:0] == 8'hc0) begin // JALR
					bus.res = bus.op1;
				end else if (bus.opn[10:0] == 11'h020) begin // JRRA
					bus.res  = bus.op1;
					bus.flag = 1'b1;
				end else if (bus.opn[4:0] == 5'b00111) begin // SRAV
					bus.res = sra;
				end
			end
			OP_BEQZ: bus.flag = (bus.op1 == '0);
			OP_BNEZ: begin
				bus.flag = (bus.op1 != '0);
				bus.res  = bus.op2; // Offset reported as is
			end
			OP_LI, OP_LW_SP, OP_SW_SP: bus.res = bus.op1;
			OP_IH_GRP: begin
				if (bus.opn[7:0] == 8'h00 || bus.opn[7:0] == 8'h01) begin // MFIH, MTIH
					bus.res = bus.op1;
				end
			end
			OP_NOP: bus.flag = (bus.opn[10:0] == 11'h000);
			OP_SHIFT: begin
				case (bus.opn[1:0])
					2'b00:   {bus.flag, bus.res} = shl; // SLL
					2'b11:   bus.res = sra;             // SRA
					2'b10:   bus.res = srl;             // SRL
					default: ;
				endcase
			end
			OP_MOVE: begin
				if (bus.opn[4:0] == 5'b00000) begin
					bus.res = bus.op1;
				end
			end
			default: ; // Unlisted words give zero
		endcase
	end

endmodule

//--- hw/exec_ctrl.sv
`timescale 1ns/1ps
`include "mips16_macros.svh"

module exec_ctrl import mips16_pkg::*; (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               req,
	output logic               ack,
	input  logic [`WORD_W-1:0] instr,
	input  logic [`WORD_W-1:0] pc,
	output logic [`WORD_W-1:0] instr_q,
	output logic [`WORD_W-1:0] pc_q,
	input  decode_t            dec,
	alu_if.ctrl                bus,
	output logic               wr_en,
	output reg_idx_t           wr_idx,
	output logic [`WORD_W-1:0] wr_data,
	output logic [`WORD_W-1:0] res,
	output logic               flag
);

	exec_state_t state;

	////////////////////////////////////////////////////////////////////////////
	// Handshake FSM and result capture

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			ack   <= 1'b0;
			res   <= '0;
			flag  <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (req) begin
						state <= EXEC;
					end
				end
				EXEC: begin // ALU path has settled by now
					res   <= bus.res;
					flag  <= bus.flag;
					ack   <= 1'b1;
					state <= ACK;
				end
				ACK: begin
					if (!req) begin // Hold ack while req stays up
						ack   <= 1'b0;
						state <= RELEASE;
					end
				end
				RELEASE: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && req) begin
			instr_q <= instr;
			pc_q    <= pc;
		end
	end

	// Register file commits on the edge that leaves EXEC
	assign wr_en   = (state == EXEC) && dec.wb_en;
	assign wr_idx  = dec.wb_idx;
	assign wr_data = dec.wb_flag ? {{(`WORD_W-1){1'b0}}, bus.flag} : bus.res;

	a_ack_after_req: assert property (
		@(posedge clk) disable iff (!arst_n)
		$rose(ack) |-> $past(req)
	) else $error("exec_ctrl: ack raised without a pending req");

	// Only CMP writes a flag, and its target is T
	a_flag_wr_to_t: assert property (
		@(posedge clk) disable iff (!arst_n)
		(wr_en && dec.wb_flag) |-> (wr_idx == REG_T)
	) else $error("exec_ctrl: flag writeback to index %0d", wr_idx);

endmodule

//--- hw/exec_top.sv
`timescale 1ns/1ps
`include "mips16_macros.svh"

module exec_top import mips16_pkg::*; (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               req,
	output logic               ack,
	input  logic [`WORD_W-1:0] instr,
	input  logic [`WORD_W-1:0] pc,
	output logic [`WORD_W-1:0] res,
	output logic               flag
);

	logic [`WORD_W-1:0] instr_q;
	logic [`WORD_W-1:0] pc_q;
	decode_t            dec;
	reg_idx_t           rd_idx_a;
	reg_idx_t           rd_idx_b;
	logic [`WORD_W-1:0] rd_data_a;
	logic [`WORD_W-1:0] rd_data_b;
	logic               wr_en;
	reg_idx_t           wr_idx;
	logic [`WORD_W-1:0] wr_data;

	alu_if alu_bus ();

	exec_ctrl u_ctrl (
		.clk     (clk),
		.arst_n  (arst_n),
		.req     (req),
		.ack     (ack),
		.instr   (instr),
		.pc      (pc),
		.instr_q (instr_q),
		.pc_q    (pc_q),
		.dec     (dec),
		.bus     (alu_bus.ctrl),
		.wr_en   (wr_en),
		.wr_idx  (wr_idx),
		.wr_data (wr_data),
		.res     (res),
		.flag    (flag)
	);

	operand_decode u_decode (
		.instr     (instr_q), // Latched copy, held through EXEC
		.pc        (pc_q),
		.rd_idx_a  (rd_idx_a),
		.rd_idx_b  (rd_idx_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.dec       (dec),
		.bus       (alu_bus.decode)
	);

	reg_file u_regs (
		.clk       (clk),
		.arst_n    (arst_n),
		.rd_idx_a  (rd_idx_a),
		.rd_idx_b  (rd_idx_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.wr_en     (wr_en),
		.wr_idx    (wr_idx),
		.wr_data   (wr_data)
	);

	alu u_alu (
		.bus (alu_bus.alu)
	);

endmodule

//--- test/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	initial begin
		arst_n = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		arst_n = 1'b1; // Released 1 ns after the 8th edge
	end

endmodule

//--- test/exec_check.sv
`timescale 1ns/1ps

module exec_check (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        req,
	input  logic        ack,
	input  logic [15:0] res,
	input  logic        flag,
	input  logic [15:0] exp_res,
	input  logic        exp_flag,
	input  int          test_num,
	output int          pass_cnt,
	output int          fail_cnt,
	output int          err_cnt
);

	logic        prev_req;
	logic        prev_ack;
	logic [15:0] prev_res;
	logic        prev_flag;
	int          wait_cnt;     // Falling edges seen with req up and ack still low
	bit          out_of_reset;

	initial begin
		pass_cnt     = 0;
		fail_cnt     = 0;
		err_cnt      = 0;
		wait_cnt     = 0;
		out_of_reset = 1'b0;
		prev_req     = 1'b0;
		prev_ack     = 1'b0;
		prev_res     = 16'h0000;
		prev_flag    = 1'b0;
	end

	task automatic protocol_error(input string what);
		$display("Handshake error at %0t ns: %s", $time, what);
		err_cnt++;
	endtask

	task automatic check_result();
		bit bad;
		bad = 1'b0;
		if (!prev_req) begin
			$display("Test %0d: ack rose although req was low", test_num);
			bad = 1'b1;
		end
		if (wait_cnt != 2) begin
			$display("Test %0d: ack rose %0d clock edges after req instead of 2",
				test_num, wait_cnt);
			bad = 1'b1;
		end
		if (res !== exp_res) begin
			$display("FAILED test %0d: res got 0x%04h, expected 0x%04h",
				test_num, res, exp_res);
			bad = 1'b1;
		end
		if (flag !== exp_flag) begin
			$display("FAILED test %0d: flag got 0x%0h, expected 0x%0h",
				test_num, flag, exp_flag);
			bad = 1'b1;
		end
		if (bad) begin
			fail_cnt++;
		end else begin
			pass_cnt++;
			$display("Test %0d passed: res 0x%04h flag %0d", test_num, res, flag);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Sampled on the falling edge, away from DUT and driver updates

	always @(negedge clk) begin
		if (!arst_n) begin
			if (ack !== 1'b0) begin
				$display("FAILED during reset: ack got 0x%0h, expected 0x0", ack);
				err_cnt++;
			end
			out_of_reset = 1'b0;
			wait_cnt     = 0;
		end else begin
			if (!out_of_reset) begin // Output registers must come up cleared
				if (res !== 16'h0000) begin
					$display("FAILED after reset: res got 0x%04h, expected 0x0000", res);
					err_cnt++;
				end
				if (flag !== 1'b0) begin
					$display("FAILED after reset: flag got 0x%0h, expected 0x0", flag);
					err_cnt++;
				end
			end
			if (req && !ack) begin
				wait_cnt++;
				if (wait_cnt == 3) begin
					protocol_error($sformatf("test %0d got no ack within 2 clock edges of req",
						test_num));
				end
			end
			if (ack && !prev_ack) begin
				check_result();
				wait_cnt = 0;
			end
			if (prev_ack && !ack && prev_req) begin
				protocol_error("ack fell while req was still high");
			end
			if (prev_ack && ack && !prev_req) begin
				protocol_error("ack still high one edge after req fell");
			end
			if (prev_ack && ack && (res !== prev_res || flag !== prev_flag)) begin
				protocol_error("res or flag changed while ack was high");
			end
			out_of_reset = 1'b1;
		end
		prev_req  = req;
		prev_ack  = ack;
		prev_res  = res;
		prev_flag = flag;
	end

endmodule

//--- test/exec_tb.sv
`timescale 1ns/1ps

module exec_tb;

	localparam string STIM_FILE = "test/exec_stim.txt";

	logic        clk;
	logic        arst_n;
	logic        req;
	logic        ack;
	logic [15:0] instr;
	logic [15:0] pc;
	logic [15:0] res;
	logic        flag;
	logic [15:0] exp_res;
	logic        exp_flag;
	int          test_num;
	int          pass_cnt;
	int          fail_cnt;
	int          err_cnt;

	logic [15:0] stim_instr[$];
	logic [15:0] stim_pc[$];
	logic [15:0] stim_res[$];
	logic        stim_flag[$];

	bit          stim_ok;
	int          cycle_cnt = 0;
	int          cycle_limit;

	clk_gen u_clk (
		.clk    (clk),
		.arst_n (arst_n)
	);

	exec_top dut (
		.clk    (clk),
		.arst_n (arst_n),
		.req    (req),
		.ack    (ack),
		.instr  (instr),
		.pc     (pc),
		.res    (res),
		.flag   (flag)
	);

	exec_check chk (
		.clk      (clk),
		.arst_n   (arst_n),
		.req      (req),
		.ack      (ack),
		.res      (res),
		.flag     (flag),
		.exp_res  (exp_res),
		.exp_flag (exp_flag),
		.test_num (test_num),
		.pass_cnt (pass_cnt),
		.fail_cnt (fail_cnt),
		.err_cnt  (err_cnt)
	);

	task automatic load_stim(output bit ok);
		int          fd;
		int          n;
		string       line;
		logic [15:0] f_instr;
		logic [15:0] f_pc;
		logic [15:0] f_res;
		logic [15:0] f_flag;
		ok = 1'b0;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("Cannot open the stimulus file %s", STIM_FILE);
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n    = $fgets(line, fd);
				if (n > 0 && line.len() > 0 && line.getc(0) != "#") begin
					n = $sscanf(line, "%h %h %h %h", f_instr, f_pc, f_res, f_flag);
					if (n == 4) begin
						stim_instr.push_back(f_instr);
						stim_pc.push_back(f_pc);
						stim_res.push_back(f_res);
						stim_flag.push_back(f_flag[0]);
					end
				end
			end
			$fclose(fd);
			ok = (stim_instr.size() > 0);
			if (!ok) begin
				$display("The stimulus file %s holds no test lines", STIM_FILE);
			end
		end
	endtask

	task automatic wait_for_ack(input logic level);
		do begin
			@(posedge clk);
			#1;
		end while (ack !== level);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// One four-phase transaction

	task automatic run_test(input int idx);
		int gap;
		int hold;
		gap  = $urandom_range(3, 0);
		hold = idx % 3; // Keeps req up a while after ack
		@(posedge clk); // FSM passes through RELEASE
		repeat (gap) @(posedge clk);
		#1;
		instr    = stim_instr[idx];
		pc       = stim_pc[idx];
		exp_res  = stim_res[idx];
		exp_flag = stim_flag[idx];
		test_num = idx + 1;
		req      = 1'b1;
		wait_for_ack(1'b1);
		repeat (hold) begin
			@(posedge clk);
			#1;
		end
		req = 1'b0;
		wait_for_ack(1'b0);
	endtask

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("Timeout: the run was stopped after %0d clock cycles", cycle_cnt);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	initial begin
		req         = 1'b0;
		instr       = 16'h0000;
		pc          = 16'h0000;
		exp_res     = 16'h0000;
		exp_flag    = 1'b0;
		test_num    = 0;
		cycle_limit = 8 + 50;
		void'($urandom(68));
		load_stim(stim_ok);
		cycle_limit = 8 + 12 * stim_instr.size() + 50;
		if (stim_ok) begin
			@(posedge arst_n);
			for (int i = 0; i < stim_instr.size(); i++) begin
				run_test(i);
			end
			repeat (2) @(posedge clk); // Last ack fall reaches the checker
		end
		if (stim_ok && pass_cnt + fail_cnt != stim_instr.size()) begin
			$display("Only %0d of %0d tests reached ack", pass_cnt + fail_cnt,
				stim_instr.size());
		end
		$display("Tests: %0d passed, %0d failed, %0d other errors", pass_cnt, fail_cnt,
			err_cnt);
		if (stim_ok && fail_cnt == 0 && err_cnt == 0 && pass_cnt == stim_instr.size()) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- test/exec_stim.txt
# instr pc   res  flag   all hex, one test per line, text after the 4th column is ignored
# Registers start at zero and each line runs on the state left by the lines above it
6812 0100 0012 0   LI R0,0x12
6934 0101 0034 0   LI R1,0x34
6B80 0102 0080 0   LI R3,0x80
7C20 0103 0034 0   MOVE R4,R1
E035 0104 0046 0   ADDU R0,R1,R5
E03B 0105 FFDE 1   SUBU R0,R1,R6 borrow
4E30 0106 000E 1   ADDIU R6,0x30 carry
E5DD 0107 0054 0   ADDU R5,R6,R7
E82D 0108 0036 0   OR R0,R1
EF2C 0109 0014 0   AND R7,R1
E80A 010A 0000 0   CMP R0,R0 T=0
6005 010B 0000 1   BTEQZ
E82A 010C 0000 1   CMP R0,R1 T=1
6005 010D 0000 0   BTEQZ
3360 010E 8000 0   SLL R3,R3,8
3463 010F FF80 0   SRA R4,R3,8
3562 0110 0080 0   SRL R5,R3,8
EE87 0111 FFFF 0   SRAV R6,R4 by 14
2210 0112 0000 1   BEQZ R2
2AF0 0113 FFF0 0   BNEZ R2
2908 0114 0008 1   BNEZ R1
ED40 0115 0115 0   MFPC R5
9903 0116 0037 0   LW R1,3
D91F 0117 0033 1   SW R1,-1
7B20 0118 0034 0   MOVE R3,R1

//--- src.f
+incdir+hw
hw/mips16_pkg.sv
hw/alu_if.sv
hw/operand_decode.sv
hw/reg_file.sv
hw/alu.sv
hw/exec_ctrl.sv
hw/exec_top.sv
test/clk_gen.sv
test/exec_check.sv
test/exec_tb.sv

//--- run.sh
#!/bin/sh
# Builds the execute subsystem testbench with Verilator and runs it

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module exec_tb -o exec_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/exec_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
	exit 1
fi
exit 0
